// File: icache.f
hw/icachePkg.sv
hw/icacheTable.sv
hw/lineFiller.sv
hw/icacheData.sv
hw/icacheTop.sv
verif/clockGen.sv
verif/icacheTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= icacheTb
FILELIST ?= icache.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert --timescale 1ns/1ps
PASS_TEXT ?= RESULT: PASS

SOURCES := $(wildcard hw/*.sv verif/*.sv)
SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// File: verif/icacheTb.sv
`timescale 1ns/1ps
`default_nettype none

module icacheTb;
    import icachePkg::*;

    localparam int NUM_LINES = 8;
    localparam int SEED = 98;
    localparam int NUM_LOOKUPS = 400;
    localparam int NUM_TAGS = 12;              // More tags than lines, forces evictions
    localparam int IDLE_CYCLES = 10;
    localparam int DRAIN_CYCLES = 8;
    localparam int CYCLES_PER_LOOKUP = 40;     // Worst case is a full miss
    localparam int TIMEOUT_CYCLES = NUM_LOOKUPS * CYCLES_PER_LOOKUP + 4000;
    localparam int FILL_BUSY = LINE_BLOCKS + 1;   // Request cycles plus the last write

    logic clk;
    logic rst;
    logic lookupValid;
    logic [30:0] lookupPc;
    logic stall;
    logic fetchValid;
    logic [63:0] fetchData;
    logic extReq;
    logic [29:0] extAddr;
    logic [63:0] extData;

    // Reference tag table
    logic [TAG_BITS-1:0] mTag [NUM_LINES];
    bit mValid [NUM_LINES];
    bit mUsed [NUM_LINES];
    int mPtr;
    bit mLoading;
    bit mWait;
    logic [TAG_BITS-1:0] mLoadTag;
    bit mCmd;
    logic [29:0] mCmdBase;

    // Reference filler, phase 0 is idle
    int fillPhase;
    logic [29:0] fillBase;
    int reqSeen;

    bit expFetchValid;
    logic [63:0] expFetchData;

    bit memPending;
    logic [29:0] memAddr;

    logic [TAG_BITS-1:0] tagPool [NUM_TAGS];
    bit everFilled [logic [TAG_BITS-1:0]];

    int errorCount;
    int issued;
    int acceptedCount;
    int fillCount;
    int refillCount;
    int cycleCount;

    clockGen clkGen_i (
        .clk(clk),
        .rst(rst)
    );

    icacheTop #(
        .NUM_LINES(NUM_LINES)
    ) dut_i (
        .clk(clk),
        .rst(rst),
        .lookupValid(lookupValid),
        .lookupPc(lookupPc),
        .stall(stall),
        .fetchValid(fetchValid),
        .fetchData(fetchData),
        .extReq(extReq),
        .extAddr(extAddr),
        .extData(extData)
    );

    task automatic checkValue(input string name, input logic [63:0] got,
                              input logic [63:0] expected);
        if (got !== expected) begin
            errorCount++;
            $display("ERROR %s: got %h, expected %h (time %0t)", name, got, expected, $time);
        end
    endtask

    // Memory contents, one 64-bit block per block address
    function automatic logic [63:0] blockHash(input logic [29:0] blockAddr);
        logic [63:0] x;
        x = 64'(blockAddr) * 64'h9E37_79B9_7F4A_7C15;
        x = x ^ (x >> 29) ^ {blockAddr[13:0], blockAddr, blockAddr[29:10]};
        return x;
    endfunction

    function automatic int findLine(input logic [TAG_BITS-1:0] tag);
        for (int i = 0; i < NUM_LINES; i++) begin
            if (mValid[i] && mTag[i] == tag)
                return i;
        end
        return -1;
    endfunction

    function automatic bit expectStall(input bit lv, input logic [30:0] pc);
        return lv && (findLine(pc[30:8]) < 0 || mLoading);
    endfunction

    // Advance the reference by one rising edge
    task automatic stepModel(input bit lv, input logic [30:0] pc, output bit accepted);
        int line;
        bit busy;
        bit doCommit;
        bit doIssue;
        bit doAdvance;
        line = findLine(pc[30:8]);
        busy = (fillPhase != 0);
        accepted = lv && line >= 0 && !mLoading;
        doCommit = mLoading && !busy && !mWait;
        doIssue = !mLoading && lv && line < 0 && !busy;
        doAdvance = !mLoading && !doIssue && mValid[mPtr] && mUsed[mPtr];

        if (lv && line >= 0)
            mUsed[line] = 1'b1;

        if (busy) begin
            fillPhase++;
            if (fillPhase > FILL_BUSY) begin
                checkValue("extReqCount", 64'(reqSeen), 64'(LINE_BLOCKS));
                fillPhase = 0;
            end
        end else if (mCmd) begin
            fillPhase = 1;
            fillBase = mCmdBase;
            reqSeen = 0;
        end

        mCmd = doIssue;
        mWait = doIssue;
        if (doIssue) begin
            mCmdBase = {2'b00, pc[30:8], 5'b00000};
            mValid[mPtr] = 1'b0;             // Victim leaves at fill start
            mLoadTag = pc[30:8];
            mLoading = 1'b1;
            if (everFilled.exists(pc[30:8]))
                refillCount++;
            everFilled[pc[30:8]] = 1'b1;
        end else if (doCommit) begin
            mTag[mPtr] = mLoadTag;
            mValid[mPtr] = 1'b1;
            mPtr = (mPtr + 1) % NUM_LINES;
            mLoading = 1'b0;
            fillCount++;
        end else if (doAdvance) begin
            mPtr = (mPtr + 1) % NUM_LINES;
        end

        expFetchValid = accepted;
        if (accepted)
            expFetchData = blockHash({2'b00, pc[30:3]});
    endtask

    task automatic runCycle(input bit newLookups);
        bit accepted;
        bit expExtReq;
        int pick;
        @(negedge clk);
        stepModel(lookupValid, lookupPc, accepted);
        if (accepted)
            acceptedCount++;

        checkValue("fetchValid", 64'(fetchValid), 64'(expFetchValid));
        if (expFetchValid)
            checkValue("fetchData", fetchData, expFetchData);
        expExtReq = fillPhase >= 1 && fillPhase <= LINE_BLOCKS;
        checkValue("extReq", 64'(extReq), 64'(expExtReq));
        if (expExtReq)
            checkValue("extAddr", 64'(extAddr), 64'(fillBase + 30'(fillPhase - 1)));
        if (extReq)
            reqSeen++;

        // Memory answers the request seen one cycle ago
        extData = memPending ? blockHash(memAddr) : {$urandom, $urandom};
        memPending = extReq;
        memAddr = extAddr;

        if (lookupValid && !accepted) begin
            // Held until accepted
        end else if (newLookups && issued < NUM_LOOKUPS && ($urandom % 4) != 0) begin
            pick = int'($urandom % NUM_TAGS);
            lookupPc = {tagPool[pick], 8'($urandom)};
            lookupValid = 1'b1;
            issued++;
        end else begin
            lookupValid = 1'b0;
            lookupPc = 31'($urandom);
        end

        #1;
        checkValue("stall", 64'(stall), 64'(expectStall(lookupValid, lookupPc)));
    endtask

    task automatic finishRun(input bit timedOut);
        $display("Lookups %0d, fills %0d, refills %0d, errors %0d",
                 acceptedCount, fillCount, refillCount, errorCount);
        if (timedOut || errorCount != 0)
            $display("RESULT: FAIL");
        else
            $display("RESULT: PASS");
        $finish;
    endtask

    initial begin
        void'($urandom(SEED));
        lookupValid = 1'b0;
        lookupPc = '0;
        extData = '0;
        errorCount = 0;
        issued = 0;
        acceptedCount = 0;
        fillCount = 0;
        refillCount = 0;
        for (int i = 0; i < NUM_LINES; i++) begin
            mTag[i] = '0;
            mValid[i] = 1'b0;
            mUsed[i] = 1'b0;
        end
        mPtr = 0;
        mLoading = 1'b0;
        mWait = 1'b0;
        mCmd = 1'b0;
        fillPhase = 0;
        reqSeen = 0;
        expFetchValid = 1'b0;
        memPending = 1'b0;
        for (int i = 0; i < NUM_TAGS; i++)
            tagPool[i] = {19'($urandom), 4'(i)};   // Low bits keep the tags distinct

        wait (rst == 1'b0);
        repeat (IDLE_CYCLES) runCycle(1'b0);
        while (issued < NUM_LOOKUPS || lookupValid)
            runCycle(1'b1);
        repeat (DRAIN_CYCLES) runCycle(1'b0);

        if (acceptedCount != NUM_LOOKUPS) begin
            errorCount++;
            $display("Only %0d of %0d lookups were accepted", acceptedCount, NUM_LOOKUPS);
        end
        if (fillCount <= NUM_LINES || refillCount == 0) begin
            errorCount++;
            $display("Evictions were not exercised, %0d fills and %0d refills",
                     fillCount, refillCount);
        end
        finishRun(1'b0);
    end

    initial begin
        cycleCount = 0;
        while (cycleCount < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        finishRun(1'b1);
    end

endmodule

`default_nettype wire

// File: verif/clockGen.sv
`timescale 1ns/1ps
`default_nettype none

module clockGen #(
    parameter int HALF_PERIOD = 10,
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic rst
);
    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // Reset drops on a falling edge, away from the sampling edge
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

`default_nettype wire

// File: hw/icacheTop.sv
`timescale 1ns/1ps
`default_nettype none

module icacheTop #(
    parameter int NUM_LINES = 8
) (
    input wire logic clk,
    input wire logic rst,

    input wire logic lookupValid,
    input wire logic [30:0] lookupPc,
    output logic stall,

    output logic fetchValid,
    output logic [63:0] fetchData,

    output logic extReq,
    output logic [29:0] extAddr,
    input wire logic [63:0] extData
);
    import icachePkg::*;

    localparam int ADDR_BITS = $clog2(NUM_LINES * LINE_BLOCKS);

    MemcCmd memc;
    MemcStat memcStat;

    logic [ADDR_BITS-1:0] lookupAddr;
    logic rdEn;

    logic fillWrEn;
    logic [9:0] fillWrAddr;
    logic [63:0] fillWrData;

    icacheTable #(
        .NUM_LINES(NUM_LINES)
    ) table_i (
        .clk(clk),
        .rst(rst),
        .lookupValid(lookupValid),
        .lookupPc(lookupPc),
        .lookupAddr(lookupAddr),
        .stall(stall),
        .memc(memc),
        .memcStat(memcStat)
    );

    lineFiller filler_i (
        .clk(clk),
        .rst(rst),
        .memc(memc),
        .memcStat(memcStat),
        .extReq(extReq),
        .extAddr(extAddr),
        .extData(extData),
        .wrEn(fillWrEn),
        .wrAddr(fillWrAddr),
        .wrData(fillWrData)
    );

    assign rdEn = lookupValid && !stall;   // Accepted lookup

    icacheData #(
        .NUM_LINES(NUM_LINES)
    ) data_i (
        .clk(clk),
        .wrEn(fillWrEn),
        .wrAddr(fillWrAddr[ADDR_BITS-1:0]),  // Only the used lines exist
        .wrData(fillWrData),
        .rdEn(rdEn),
        .rdAddr(lookupAddr),
        .rdData(fetchData)
    );

    always_ff @(posedge clk) begin
        if (rst)
            fetchValid <= 1'b0;
        else
            fetchValid <= rdEn;
    end

endmodule

`default_nettype wire

// File: hw/icacheData.sv
`timescale 1ns/1ps
`default_nettype none

module icacheData #(
    parameter int NUM_LINES = 8
) (
    input wire logic clk,

    input wire logic wrEn,
    input wire logic [$clog2(NUM_LINES*icachePkg::LINE_BLOCKS)-1:0] wrAddr,
    input wire logic [63:0] wrData,

    input wire logic rdEn,
    input wire logic [$clog2(NUM_LINES*icachePkg::LINE_BLOCKS)-1:0] rdAddr,
    output logic [63:0] rdData
);
    import icachePkg::*;

    localparam int DEPTH = NUM_LINES * LINE_BLOCKS;

    logic [63:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (wrEn)
            mem[wrAddr] <= wrData;
    end

    // Registered read, block shows up the cycle after the hit
    always_ff @(posedge clk) begin
        if (rdEn)
            rdData <= mem[rdAddr];
    end

endmodule

`default_nettype wire

// File: hw/lineFiller.sv
`timescale 1ns/1ps
`default_nettype none

module lineFiller (
    input wire logic clk,
    input wire logic rst,

    input wire icachePkg::MemcCmd memc,
    output icachePkg::MemcStat memcStat,

    output logic extReq,
    output logic [29:0] extAddr,      // Block units
    input wire logic [63:0] extData,

    output logic wrEn,
    output logic [9:0] wrAddr,        // Block units
    output logic [63:0] wrData
);
    import icachePkg::*;

    localparam int BLK_BITS = $clog2(LINE_BLOCKS);

    logic busy;
    logic reqActive;
    logic wrPending;                  // Read issued last cycle, data arrives now
    logic [BLK_BITS-1:0] reqCnt;
    logic [BLK_BITS-1:0] wrCnt;
    logic [1:0] rqId;

    // Command addresses are 16-bit units, four per block
    logic [27:0] extBase;
    logic [9:0] sramBase;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            reqActive <= 1'b0;
            wrPending <= 1'b0;
            reqCnt <= '0;
            wrCnt <= '0;
            rqId <= '0;
        end else begin
            wrPending <= reqActive;

            if (!busy && memc.cmd == MEMC_CP_EXT_TO_CACHE) begin
                busy <= 1'b1;
                reqActive <= 1'b1;
                reqCnt <= '0;
                wrCnt <= '0;
                rqId <= memc.rqId;
            end else begin
                if (reqActive) begin
                    reqCnt <= reqCnt + 1'b1;
                    if (reqCnt == BLK_BITS'(LINE_BLOCKS - 1))
                        reqActive <= 1'b0;
                end
                if (wrPending) begin
                    wrCnt <= wrCnt + 1'b1;
                    if (wrCnt == BLK_BITS'(LINE_BLOCKS - 1))
                        busy <= 1'b0;   // Last block written
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!busy && memc.cmd == MEMC_CP_EXT_TO_CACHE) begin
            extBase <= memc.extAddr[29:2];
            sramBase <= memc.sramAddr[11:2];
        end
    end

    assign extReq = reqActive;
    assign extAddr = {2'b00, extBase + 28'(reqCnt)};

    // Memory answers one cycle after the request
    assign wrEn = wrPending;
    assign wrAddr = sramBase + 10'(wrCnt);
    assign wrData = extData;

    assign memcStat = '{busy: busy, progress: {wrCnt, 2'b00}, rqId: rqId};

    noCmdWhileBusy: assert property (
        @(posedge clk) disable iff (rst)
        (memc.cmd != MEMC_NONE) |-> !busy
    );

endmodule

`default_nettype wire

// File: hw/icacheTable.sv
`timescale 1ns/1ps
`default_nettype none

module icacheTable #(
    parameter int NUM_LINES = 8
) (
    input wire logic clk,
    input wire logic rst,

    input wire logic lookupValid,
    input wire logic [30:0] lookupPc,

    output logic [$clog2(NUM_LINES*icachePkg::LINE_BLOCKS)-1:0] lookupAddr,
    output logic stall,

    output icachePkg::MemcCmd memc,
    input wire icachePkg::MemcStat memcStat
);
    import icachePkg::*;

    localparam int IDX_BITS = $clog2(NUM_LINES);

    TagEntry tags [NUM_LINES];

    logic [NUM_LINES-1:0] matchVec;
    logic hit;
    logic [IDX_BITS-1:0] hitIdx;

    logic [IDX_BITS-1:0] replPtr;     // Rotating replacement pointer
    logic [TAG_BITS-1:0] loadTag;
    logic loading;
    logic waitFill;                   // Filler has not yet raised busy

    // Tag compare against every valid entry
    always_comb begin
        for (int i = 0; i < NUM_LINES; i++) begin
            matchVec[i] = tags[i].valid && (tags[i].addr == lookupPc[30:8]);
        end
    end

    always_comb begin
        hitIdx = '0;
        for (int i = 0; i < NUM_LINES; i++) begin
            if (matchVec[i])
                hitIdx = IDX_BITS'(i);
        end
    end

    assign hit = |matchVec;
    assign lookupAddr = {hitIdx, lookupPc[7:3]};

    // Hold fetch while the line is missing or a fill is running
    assign stall = lookupValid && (!hit || loading);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_LINES; i++) begin
                tags[i].valid <= 1'b0;
                tags[i].used <= 1'b0;
            end
            replPtr <= '0;
            loading <= 1'b0;
            waitFill <= 1'b0;
            memc.cmd <= MEMC_NONE;
        end else begin
            memc.cmd <= MEMC_NONE;
            waitFill <= 1'b0;

            if (lookupValid && hit)
                tags[hitIdx].used <= 1'b1;

            if (loading && !memcStat.busy && !waitFill) begin
                // Fill done, commit the new tag
                tags[replPtr].addr <= loadTag;
                tags[replPtr].valid <= 1'b1;
                replPtr <= replPtr + 1'b1;
                loading <= 1'b0;
            end else if (!loading && lookupValid && !hit && !memcStat.busy) begin
                memc.cmd <= MEMC_CP_EXT_TO_CACHE;
                memc.sramAddr <= 12'({replPtr, 7'b0});
                memc.extAddr <= {lookupPc[30:8], 7'b0};
                memc.cacheId <= 1'b1;
                memc.rqId <= 2'd1;
                tags[replPtr].valid <= 1'b0;   // Victim is gone as soon as the fill starts
                loadTag <= lookupPc[30:8];
                loading <= 1'b1;
                waitFill <= 1'b1;
            end else if (!loading && tags[replPtr].valid && tags[replPtr].used) begin
                replPtr <= replPtr + 1'b1;
            end
        end
    end

    // A command only goes to an idle filler, which then turns busy
    cmdToIdleFiller: assert property (
        @(posedge clk) disable iff (rst)
        (memc.cmd != MEMC_NONE) |-> !memcStat.busy ##1 memcStat.busy
    );

    // Tags are unique across the table
    singleMatch: assert property (
        @(posedge clk) disable iff (rst)
        lookupValid |-> $onehot0(matchVec)
    );

endmodule

`default_nettype wire

// File: hw/icachePkg.sv
`default_nettype none

package icachePkg;

    // Line geometry
    localparam int LINE_BLOCKS = 32;   // 64-bit fetch blocks per line
    localparam int TAG_BITS = 23;      // Program counter bits 30:8

    // Memory controller command codes
    typedef enum logic [1:0] {
        MEMC_NONE = 2'd0,
        MEMC_CP_EXT_TO_CACHE = 2'd1
    } MemcCode;

    // Copy command from the tag table to the line filler
    // Addresses are in 16-bit units, so one line spans 7 address bits
    typedef struct packed {
        MemcCode cmd;
        logic [11:0] sramAddr;     // Line index, then seven zero bits
        logic [29:0] extAddr;      // Tag, then seven zero bits
        logic cacheId;
        logic [1:0] rqId;
    } MemcCmd;

    // Status returned by the line filler
    typedef struct packed {
        logic busy;
        logic [6:0] progress;      // Blocks written times four
        logic [1:0] rqId;
    } MemcStat;

    // One tag table entry
    typedef struct packed {
        logic [TAG_BITS-1:0] addr;
        logic valid;
        logic used;               // Set on hit, makes the replacement pointer skip the entry
    } TagEntry;

endpackage

`default_nettype wire
